// File: filelist.f
design/dma_wr_pkg.sv
design/beat_if.sv
design/buf_if.sv
design/pkt_framer.sv
design/desc_tracker.sv
design/sram_word_writer.sv
design/dma_wr_top.sv
dv/dma_wr_tb.sv

// File: Bender.yml
package:
  name: dma_wr

sources:
  - target: any(rtl, test)
    files:
      - design/dma_wr_pkg.sv
      - design/beat_if.sv
      - design/buf_if.sv
      - design/pkt_framer.sv
      - design/desc_tracker.sv
      - design/sram_word_writer.sv
      - design/dma_wr_top.sv
  - target: test
    files:
      - dv/dma_wr_tb.sv

// File: dv/dma_wr_tb.sv
`timescale 1ns/100ps

module dma_wr_tb;
  import dma_wr_pkg::*;

  localparam int ADDR_W  = 32;
  localparam int N_ROWS  = 6;
  localparam int TIMEOUT = 2000;

  // one packet per row
  // a zero len1 means a single buffer
  typedef struct packed {
    logic [7:0]  n_stray;
    logic [7:0]  n_beats;
    logic [31:0] addr0;
    logic [15:0] len0;
    logic [31:0] addr1;
    logic [15:0] len1;
    logic        rand_gnt;
    logic [7:0]  hold;
  } row_t;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_data_empty;
  logic [BEAT_W-1:0] i_data;
  logic              i_desc_empty;
  logic [DESC_W-1:0] i_desc;
  logic              i_sram_gnt;
  logic              o_data_rden;
  logic              o_desc_rden;
  logic              o_sram_wren;
  logic [ADDR_W-1:0] o_sram_addr;
  logic [WORD_W-1:0] o_sram_wdata;
  logic              o_wait_desc;
  logic              o_irq_wren;
  logic [WORD_W-1:0] o_irq_data;

  row_t              rows [N_ROWS];
  logic [BEAT_W-1:0] data_q [$];
  logic [DESC_W-1:0] desc_q [$];
  logic [ADDR_W-1:0] got_addr [$];
  logic [WORD_W-1:0] got_data [$];
  logic [WORD_W-1:0] irq_q [$];
  logic [ADDR_W-1:0] exp_addr [$];
  logic [WORD_W-1:0] exp_data [$];
  logic              rand_gnt;
  integer            seed;

  dma_wr_top #(
    .ADDR_W (ADDR_W)
  ) uut (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_data_empty (i_data_empty),
    .i_data       (i_data),
    .o_data_rden  (o_data_rden),
    .i_desc_empty (i_desc_empty),
    .i_desc       (i_desc),
    .o_desc_rden  (o_desc_rden),
    .o_sram_wren  (o_sram_wren),
    .o_sram_addr  (o_sram_addr),
    .o_sram_wdata (o_sram_wdata),
    .i_sram_gnt   (i_sram_gnt),
    .o_wait_desc  (o_wait_desc),
    .o_irq_wren   (o_irq_wren),
    .o_irq_data   (o_irq_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test failures found");
    $fatal(1, "wait loop timed out");
  endtask

  // show-ahead FIFO fronts and grant change on the falling edge
  always @(negedge i_clk) begin
    i_data_empty = (data_q.size() == 0);
    i_data       = i_data_empty ? '0 : data_q[0];
    i_desc_empty = (desc_q.size() == 0);
    i_desc       = i_desc_empty ? '0 : desc_q[0];
    i_sram_gnt   = rand_gnt ? $random(seed) & 1 : 1'b1;
  end

  // FIFO pops, granted SRAM writes and interrupts
  always @(posedge i_clk) begin
    if (o_data_rden) begin
      check("i_data_empty", i_data_empty, 1'b0);
      data_q.delete(0);
    end
    if (o_desc_rden) begin
      check("i_desc_empty", i_desc_empty, 1'b0);
      desc_q.delete(0);
    end
    if (o_sram_wren && i_sram_gnt) begin
      got_addr.push_back(o_sram_addr);
      got_data.push_back(o_sram_wdata);
    end
    if (o_irq_wren) begin
      irq_q.push_back(o_irq_data);
    end
  end

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // SRAM word expected for word j of beat b in row r with all bytes distinct
  function automatic logic [31:0] word_value(input int r, input int b, input int j);
    return {4'hA, r[3:0], b[7:0], 4'h3, j[3:0], 8'hC6};
  endfunction

  // tag at the top of the beat, payload at the bottom
  function automatic logic [BEAT_W-1:0] make_beat(input logic [1:0]           tag,
                                                  input logic [PAYLOAD_W-1:0] pay);
    logic [BEAT_W-1:0] beat;
    beat                  = '0;
    beat[TAG_HI:TAG_LO]   = tag;
    beat[PAYLOAD_W-1:0]   = pay;
    return beat;
  endfunction

  task automatic load_table();
    // stray, beats, addr0, len0, addr1, len1, random grant, hold cycles
    rows[0] = {8'd0, 8'd4, 32'h0000_1000, 16'd64, 32'h0000_0000, 16'd0, 1'b0, 8'd0};
    rows[1] = {8'd0, 8'd5, 32'h4000_2040, 16'd32, 32'h0000_3100, 16'd64, 1'b0, 8'd0};
    rows[2] = {8'd3, 8'd3, 32'h0000_4000, 16'd48, 32'h0000_0000, 16'd0, 1'b0, 8'd0};
    rows[3] = {8'd0, 8'd6, 32'h0000_5000, 16'd48, 32'h0000_6008, 16'd48, 1'b1, 8'd0};
    rows[4] = {8'd1, 8'd4, 32'h0000_7000, 16'd32, 32'h0000_7800, 16'd32, 1'b0, 8'd10};
    rows[5] = {8'd2, 8'd3, 32'h8000_8000, 16'd16, 32'h0000_9000, 16'd64, 1'b1, 8'd6};
  endtask

  task automatic build_expected(input int r);
    int          left;
    int          b;
    int          j;
    logic [31:0] waddr;
    exp_addr.delete();
    exp_data.delete();
    left  = rows[r].len0 / BYTES_PER_BEAT;
    waddr = {2'b00, rows[r].addr0[31:2]};
    for (b = 0; b < rows[r].n_beats; b++) begin
      // continue in the second buffer once the first is used up
      if (left == 0) begin
        left  = rows[r].len1 / BYTES_PER_BEAT;
        waddr = {2'b00, rows[r].addr1[31:2]};
      end
      for (j = 0; j < WORDS_PER_BEAT; j++) begin
        exp_addr.push_back(waddr);
        exp_data.push_back(word_value(r, b, j));
        waddr++;
      end
      left--;
    end
  endtask

  task automatic push_beats(input int r);
    logic [1:0]           tag;
    logic [PAYLOAD_W-1:0] pay;
    int                   i;
    int                   j;
    // strays carry junk and end in a tail
    for (i = 0; i < rows[r].n_stray; i++) begin
      tag = (i == rows[r].n_stray - 1) ? TAG_TAIL : {1'b0, i[0]};
      data_q.push_back(make_beat(tag, {4{32'hBAD0_0000 + i}}));
    end
    for (i = 0; i < rows[r].n_beats; i++) begin
      if (i == 0) tag = TAG_HEAD;
      else if (i == rows[r].n_beats - 1) tag = TAG_TAIL;
      else tag = {1'b0, i[0]};
      for (j = 0; j < WORDS_PER_BEAT; j++) begin
        pay[PAYLOAD_W-1-32*j -: 32] = swap_bytes(word_value(r, i, j));
      end
      data_q.push_back(make_beat(tag, pay));
    end
  endtask

  initial begin
    int r;
    int k;
    int cnt;
    int n_irq;
    seed         = 32'h527f;
    rand_gnt     = 1'b0;
    i_rst_n      = 1'b0;
    i_data_empty = 1'b1;
    i_data       = '0;
    i_desc_empty = 1'b1;
    i_desc       = '0;
    i_sram_gnt   = 1'b0;
    load_table();
    repeat (3) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check("o_data_rden", o_data_rden, 0);
    check("o_desc_rden", o_desc_rden, 0);
    check("o_sram_wren", o_sram_wren, 0);
    check("o_irq_wren", o_irq_wren, 0);
    check("o_wait_desc", o_wait_desc, 0);

    for (r = 0; r < N_ROWS; r++) begin
      @(posedge i_clk);
      rand_gnt = rows[r].rand_gnt;
      got_addr.delete();
      got_data.delete();
      n_irq = irq_q.size();
      build_expected(r);
      desc_q.push_back({rows[r].len0, rows[r].addr0});
      if (rows[r].len1 != 0 && rows[r].hold == 0) begin
        desc_q.push_back({rows[r].len1, rows[r].addr1});
      end
      push_beats(r);

      if (rows[r].hold != 0) begin
        cnt = 0;
        while (got_addr.size() < rows[r].len0 / BYTES_PER_WORD) begin
          @(negedge i_clk);
          cnt++;
          if (cnt > TIMEOUT) timeout_fail("first buffer never filled");
        end
        cnt = 0;
        while (!o_wait_desc) begin
          @(negedge i_clk);
          cnt++;
          if (cnt > TIMEOUT) timeout_fail("o_wait_desc not raised while out of descriptors");
        end
        repeat (rows[r].hold) begin
          @(negedge i_clk);
          check("o_wait_desc", o_wait_desc, 1);
          check("write count while starved", got_addr.size(), rows[r].len0 / BYTES_PER_WORD);
        end
        @(posedge i_clk);
        desc_q.push_back({rows[r].len1, rows[r].addr1});
      end

      cnt = 0;
      while (irq_q.size() == n_irq) begin
        @(negedge i_clk);
        cnt++;
        if (cnt > TIMEOUT) timeout_fail("no interrupt seen after packet");
      end
      // idle tail to catch a second interrupt or a late write
      repeat (8) @(negedge i_clk);
      check("interrupt count", irq_q.size(), n_irq + 1);
      check("o_irq_data", irq_q[n_irq], {1'b1, rows[r].addr0[30:0]});
      check("write count", got_addr.size(), exp_addr.size());
      for (k = 0; k < exp_addr.size(); k++) begin
        check("o_sram_addr", got_addr[k], exp_addr[k]);
        check("o_sram_wdata", got_data[k], exp_data[k]);
      end
      check("data FIFO level", data_q.size(), 0);
      check("descriptor FIFO level", desc_q.size(), 0);
      check("o_wait_desc", o_wait_desc, 0);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: design/dma_wr_top.sv
`timescale 1ns/100ps

module dma_wr_top #(
  parameter int ADDR_W = 32
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // packet data FIFO
  input  logic                          i_data_empty,
  input  logic [dma_wr_pkg::BEAT_W-1:0] i_data,
  output logic                          o_data_rden,
  // descriptor FIFO
  input  logic                          i_desc_empty,
  input  logic [dma_wr_pkg::DESC_W-1:0] i_desc,
  output logic                          o_desc_rden,
  // data SRAM
  output logic                          o_sram_wren,
  output logic [ADDR_W-1:0]             o_sram_addr,
  output logic [dma_wr_pkg::WORD_W-1:0] o_sram_wdata,
  input  logic                          i_sram_gnt,
  // status and interrupt
  output logic                          o_wait_desc,
  output logic                          o_irq_wren,
  output logic [dma_wr_pkg::WORD_W-1:0] o_irq_data
);

  beat_if u_beat ();

  buf_if #(
    .ADDR_W (ADDR_W)
  ) u_buf ();

  pkt_framer u_framer (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_data_empty (i_data_empty),
    .i_data       (i_data),
    .o_data_rden  (o_data_rden),
    .bt           (u_beat.framer)
  );

  desc_tracker #(
    .ADDR_W (ADDR_W)
  ) u_tracker (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_desc_empty (i_desc_empty),
    .i_desc       (i_desc),
    .o_desc_rden  (o_desc_rden),
    .o_wait_desc  (o_wait_desc),
    .o_irq_wren   (o_irq_wren),
    .o_irq_data   (o_irq_data),
    .bf           (u_buf.tracker)
  );

  sram_word_writer #(
    .ADDR_W (ADDR_W)
  ) u_writer (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_sram_gnt   (i_sram_gnt),
    .o_sram_wren  (o_sram_wren),
    .o_sram_addr  (o_sram_addr),
    .o_sram_wdata (o_sram_wdata),
    .bt           (u_beat.writer),
    .bf           (u_buf.writer)
  );

endmodule

// File: design/sram_word_writer.sv
`timescale 1ns/100ps

module sram_word_writer #(
  parameter int ADDR_W = 32
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_sram_gnt,
  output logic                          o_sram_wren,
  output logic [ADDR_W-1:0]             o_sram_addr,
  output logic [dma_wr_pkg::WORD_W-1:0] o_sram_wdata,
  beat_if.writer                        bt,
  buf_if.writer                         bf
);
  import dma_wr_pkg::*;

  localparam int IDX_W = $clog2(WORDS_PER_BEAT);

  logic [IDX_W-1:0]  r_idx;
  logic              r_armed;
  logic              w_go;
  logic              w_grant;
  logic              w_last_idx;
  logic [WORD_W-1:0] w_word;

  // reverse byte order inside one word
  function automatic logic [WORD_W-1:0] byte_swap(input logic [WORD_W-1:0] w);
    logic [WORD_W-1:0] s;
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      s[b*8 +: 8] = w[(BYTES_PER_WORD-1-b)*8 +: 8];
    end
    return s;
  endfunction

  assign w_go = bt.valid && bf.ready;

  // held high only while beat and buffer stay available
  assign o_sram_wren = r_armed && w_go;
  assign w_grant     = o_sram_wren && i_sram_gnt;
  assign w_last_idx  = (r_idx == IDX_W'(WORDS_PER_BEAT - 1));

  // word 0 is the top of the payload
  assign w_word = bt.payload[PAYLOAD_W-1-WORD_W*r_idx -: WORD_W];

  assign o_sram_wdata = byte_swap(w_word);
  assign o_sram_addr  = bf.addr;

  assign bt.done       = w_grant && w_last_idx;
  assign bf.advance    = w_grant;
  assign bf.head_start = w_grant && bt.head && (r_idx == '0);
  assign bf.pkt_done   = w_grant && w_last_idx && bt.last;
  assign bf.waiting    = bt.valid && !bf.ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_idx   <= '0;
      r_armed <= 1'b0;
    end else begin
      // wren follows one cycle behind beat and buffer
      r_armed <= w_go;
      if (w_grant) begin
        r_idx <= r_idx + 1'b1;
      end
    end
  end

  a_hold_until_grant : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_sram_wren && !i_sram_gnt) |=> ($stable(o_sram_addr) && $stable(o_sram_wdata))
  ) else $error("SRAM address or data moved without grant");

endmodule

// File: design/desc_tracker.sv
`timescale 1ns/100ps

module desc_tracker #(
  parameter int ADDR_W = 32
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_desc_empty,
  input  logic [dma_wr_pkg::DESC_W-1:0] i_desc,
  output logic                          o_desc_rden,
  output logic                          o_wait_desc,
  output logic                          o_irq_wren,
  output logic [dma_wr_pkg::WORD_W-1:0] o_irq_data,
  buf_if.tracker                        bf
);
  import dma_wr_pkg::*;

  // start word sits in bits 31:2 of the byte address
  localparam int ADDR_LSB = 2;
  localparam int ADDR_MSB = 31;

  logic              r_loaded;
  logic [ADDR_W-1:0] r_addr;
  logic [LEN_W-1:0]  r_remain;
  logic [30:0]       r_desc_lo;
  logic [WORD_W-1:0] r_irq_word;
  logic              w_last_word;
  logic              w_retire;

  // prefetch as soon as the slot is empty
  assign o_desc_rden = !r_loaded && !i_desc_empty;

  assign bf.ready = r_loaded;
  assign bf.addr  = r_addr;

  // this advance empties the buffer
  assign w_last_word = (r_remain <= LEN_W'(BYTES_PER_WORD));

  // buffer full, or packet over so the next one starts fresh
  assign w_retire = bf.pkt_done || (bf.advance && w_last_word);

  assign o_wait_desc = bf.waiting;
  assign o_irq_data  = r_irq_word;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_loaded   <= 1'b0;
      o_irq_wren <= 1'b0;
    end else begin
      if (o_desc_rden) begin
        r_loaded <= 1'b1;
      end else if (w_retire) begin
        r_loaded <= 1'b0;
      end
      // one cycle after the tail's last word
      o_irq_wren <= bf.pkt_done;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_desc_rden) begin
      r_addr    <= ADDR_W'(i_desc[ADDR_MSB:ADDR_LSB]);
      r_remain  <= i_desc[DESC_LEN_LSB +: LEN_W];
      r_desc_lo <= i_desc[30:0];
    end else if (bf.advance) begin
      r_addr   <= r_addr + 1'b1;
      r_remain <= r_remain - LEN_W'(BYTES_PER_WORD);
    end
  end

  // interrupt word taken from the buffer the packet started in
  always_ff @(posedge i_clk) begin
    if (bf.head_start) begin
      r_irq_word <= {1'b1, r_desc_lo};
    end
  end

  a_advance_needs_ready : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    bf.advance |-> bf.ready
  ) else $error("word granted with no descriptor loaded");

endmodule

// File: design/pkt_framer.sv
`timescale 1ns/100ps

module pkt_framer (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_data_empty,
  input  logic [dma_wr_pkg::BEAT_W-1:0] i_data,
  output logic                          o_data_rden,
  beat_if.framer                        bt
);
  import dma_wr_pkg::*;

  typedef enum logic {
    ST_FWD,
    ST_DISCARD
  } state_t;

  state_t     r_state;
  logic       r_in_pkt;
  logic [1:0] w_tag;
  logic       w_can_take;
  logic       w_capture;
  logic       w_stray;

  assign w_tag = i_data[TAG_HI:TAG_LO];

  // held register is free, or being released this cycle
  assign w_can_take = !bt.valid || bt.done;

  // inside a packet any tag is taken, outside only a head
  assign w_capture = (r_state == ST_FWD) && !i_data_empty && w_can_take &&
                     (r_in_pkt || (w_tag == TAG_HEAD));

  // outside a packet and the FIFO shows something that is not a head
  assign w_stray = (r_state == ST_FWD) && !r_in_pkt && !i_data_empty &&
                   (w_tag != TAG_HEAD);

  assign o_data_rden = w_capture || ((r_state == ST_DISCARD) && !i_data_empty);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state  <= ST_FWD;
      r_in_pkt <= 1'b0;
      bt.valid <= 1'b0;
    end else begin
      case (r_state)
        ST_FWD: begin
          if (w_stray) begin
            r_state <= ST_DISCARD;
          end
        end
        ST_DISCARD: begin
          // drop beats up to and including a tail
          if (!i_data_empty && (w_tag == TAG_TAIL)) begin
            r_state <= ST_FWD;
          end
        end
        default: begin
          r_state <= ST_FWD;
        end
      endcase

      if (w_capture) begin
        r_in_pkt <= (w_tag != TAG_TAIL);
        bt.valid <= 1'b1;
      end else if (bt.done) begin
        bt.valid <= 1'b0;
      end
    end
  end

  // beat contents
  always_ff @(posedge i_clk) begin
    if (w_capture) begin
      bt.head    <= (w_tag == TAG_HEAD);
      bt.last    <= (w_tag == TAG_TAIL);
      bt.payload <= i_data[PAYLOAD_W-1:0];
    end
  end

  a_no_pop_when_empty : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_data_rden |-> !i_data_empty
  ) else $error("data FIFO popped while empty");

endmodule

// File: design/buf_if.sv
`timescale 1ns/100ps

interface buf_if #(
  parameter int ADDR_W = 32
);

  // descriptor side
  logic              ready;
  logic [ADDR_W-1:0] addr;

  // writer side progress
  logic              waiting;
  logic              advance;
  logic              head_start;
  logic              pkt_done;

  modport writer (
    input  ready,
    input  addr,
    output waiting,
    output advance,
    output head_start,
    output pkt_done
  );

  modport tracker (
    output ready,
    output addr,
    input  waiting,
    input  advance,
    input  head_start,
    input  pkt_done
  );

endinterface

// File: design/beat_if.sv
`timescale 1ns/100ps

interface beat_if;
  import dma_wr_pkg::*;

  // held beat, stable while valid is high
  logic                 valid;
  logic                 head;
  logic                 last;
  logic [PAYLOAD_W-1:0] payload;

  // fourth word of the beat granted
  logic                 done;

  modport framer (
    output valid,
    output head,
    output last,
    output payload,
    input  done
  );

  modport writer (
    input  valid,
    input  head,
    input  last,
    input  payload,
    output done
  );

endinterface

// File: design/dma_wr_pkg.sv
package dma_wr_pkg;

  // data FIFO beat layout
  localparam int BEAT_W    = 134;
  localparam int PAYLOAD_W = 128;
  localparam int TAG_HI    = 133;
  localparam int TAG_LO    = 132;

  // tag codes, anything else is a middle beat
  localparam logic [1:0] TAG_HEAD = 2'b11;
  localparam logic [1:0] TAG_TAIL = 2'b10;

  // SRAM word geometry
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_BEAT = 4;
  localparam int BYTES_PER_WORD = 4;
  localparam int BYTES_PER_BEAT = WORDS_PER_BEAT * BYTES_PER_WORD;

  // descriptor layout
  // bits 31:2 hold the start word, length sits above the address
  localparam int DESC_W       = 48;
  localparam int DESC_LEN_LSB = 32;
  localparam int LEN_W        = 16;

endpackage
